/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// Word and address geometry
	localparam int WORD_SIZE = 16;
	localparam int ADDR_WIDTH = 16;

	// Four lines of four words
	localparam int LINE_WORDS = 4;
	localparam int LINE_WIDTH = LINE_WORDS * WORD_SIZE;
	localparam int NUM_LINES = 4;

	// Address split is {tag, index, offset}
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);
	localparam int INDEX_BITS = $clog2(NUM_LINES);
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
	localparam int LINE_ADDR_WIDTH = TAG_WIDTH + INDEX_BITS; // Memory side addresses lines

	typedef enum logic [2:0] {
		IDLE,            // Waiting for a processor request
		LOOKUP,          // Tag compare against the registered address
		WRITEBACK_REQ,   // Dirty victim offered to memory
		WRITEBACK_WAIT,
		FILL_REQ,        // Line read offered to memory
		FILL_WAIT,
		RESPOND          // One cycle of cpu_resp_valid
	} ctrl_state_t;

endpackage

`default_nettype wire

/* cache_ifs.sv */
`default_nettype none

interface tag_if
	import cache_pkg::*;
();

	logic [INDEX_BITS-1:0] index;
	logic [TAG_WIDTH-1:0]  tag;
	logic                  fill_en;     // New tag, valid set, dirty cleared
	logic                  set_dirty;
	logic                  clear_dirty;
	logic                  hit;
	logic                  victim_dirty;
	logic [TAG_WIDTH-1:0]  victim_tag;  // Tag currently held at index

	modport ctrl (
		output index, tag, fill_en, set_dirty, clear_dirty,
		input  hit, victim_dirty, victim_tag
	);

	modport store (
		input  index, tag, fill_en, set_dirty, clear_dirty,
		output hit, victim_dirty, victim_tag
	);

endinterface

interface data_if
	import cache_pkg::*;
();

	logic [INDEX_BITS-1:0]  index;
	logic [OFFSET_BITS-1:0] offset;
	logic [WORD_SIZE-1:0]   word_wdata;
	logic                   word_we;
	logic [LINE_WIDTH-1:0]  line_wdata;
	logic                   line_we;     // Wins over word_we
	logic [WORD_SIZE-1:0]   word_rdata;
	logic [LINE_WIDTH-1:0]  line_rdata;

	modport ctrl (
		output index, offset, word_wdata, word_we, line_wdata, line_we,
		input  word_rdata, line_rdata
	);

	modport store (
		input  index, offset, word_wdata, word_we, line_wdata, line_we,
		output word_rdata, line_rdata
	);

endinterface

`default_nettype wire

/* tag_store.sv */
`default_nettype none

module tag_store
	import cache_pkg::*;
(
	input  logic clk,
	input  logic reset_n,
	tag_if.store tif
);

	logic [TAG_WIDTH-1:0] tag_mem [NUM_LINES];
	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;

	// Lookup is purely combinational on the index
	assign tif.hit = valid[tif.index] && (tag_mem[tif.index] == tif.tag);
	assign tif.victim_dirty = valid[tif.index] && dirty[tif.index];
	assign tif.victim_tag = tag_mem[tif.index];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (tif.fill_en) begin
				valid[tif.index] <= 1'b1;
				dirty[tif.index] <= 1'b0; // Freshly filled line matches memory
			end else if (tif.set_dirty) begin
				dirty[tif.index] <= 1'b1;
			end else if (tif.clear_dirty) begin
				dirty[tif.index] <= 1'b0; // Write-back done
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tif.fill_en) begin
			tag_mem[tif.index] <= tif.tag;
		end
	end

endmodule

`default_nettype wire

/* data_store.sv */
`default_nettype none

module data_store
	import cache_pkg::*;
(
	input  logic  clk,
	data_if.store dif
);

	// Word 0 sits in the low bits of a line
	logic [LINE_WORDS-1:0][WORD_SIZE-1:0] lines [NUM_LINES];
	logic [LINE_WORDS-1:0][WORD_SIZE-1:0] cur_line;

	assign cur_line = lines[dif.index];

	assign dif.word_rdata = cur_line[dif.offset];
	assign dif.line_rdata = cur_line;

	always_ff @(posedge clk) begin
		if (dif.line_we) begin
			lines[dif.index] <= dif.line_wdata; // Fill from memory
		end else if (dif.word_we) begin
			lines[dif.index][dif.offset] <= dif.word_wdata;
		end
	end

endmodule

`default_nettype wire

/* cache_controller.sv */
`default_nettype none

module cache_controller
	import cache_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset_n,

	input  logic                       cpu_req_valid,
	output logic                       cpu_req_ready,
	input  logic                       cpu_req_write,
	input  logic [ADDR_WIDTH-1:0]      cpu_req_addr,
	input  logic [WORD_SIZE-1:0]       cpu_req_wdata,
	output logic                       cpu_resp_valid,
	output logic [WORD_SIZE-1:0]       cpu_resp_rdata,

	output logic                       mem_req_valid,
	input  logic                       mem_req_ready,
	output logic                       mem_req_write,
	output logic [LINE_ADDR_WIDTH-1:0] mem_req_addr,
	output logic [LINE_WIDTH-1:0]      mem_req_wdata,
	input  logic                       mem_resp_valid,
	input  logic [LINE_WIDTH-1:0]      mem_resp_rdata,

	output logic [WORD_SIZE-1:0]       num_access,
	output logic [WORD_SIZE-1:0]       num_hit,

	tag_if.ctrl                        tif,
	data_if.ctrl                       dif
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	logic                   req_write;
	logic [ADDR_WIDTH-1:0]  req_addr;
	logic [WORD_SIZE-1:0]   req_wdata;
	logic [TAG_WIDTH-1:0]   req_tag;
	logic [INDEX_BITS-1:0]  req_index;
	logic [OFFSET_BITS-1:0] req_offset;

	logic                   accept;
	logic                   lookup_hit;
	logic                   fill_done;
	logic                   wb_done;
	logic                   missed;     // First lookup of this request missed
	logic [WORD_SIZE-1:0]   resp_rdata;

	assign accept = cpu_req_valid && cpu_req_ready;
	assign {req_tag, req_index, req_offset} = req_addr;
	assign lookup_hit = (state == LOOKUP) && tif.hit;
	assign fill_done = (state == FILL_WAIT) && mem_resp_valid;
	assign wb_done = (state == WRITEBACK_WAIT) && mem_resp_valid;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_next = LOOKUP;
				end
			end
			LOOKUP: begin
				if (tif.hit) begin
					state_next = RESPOND;
				end else if (tif.victim_dirty) begin
					state_next = WRITEBACK_REQ;
				end else begin
					state_next = FILL_REQ;
				end
			end
			WRITEBACK_REQ: begin
				if (mem_req_ready) begin
					state_next = WRITEBACK_WAIT;
				end
			end
			WRITEBACK_WAIT: begin
				if (mem_resp_valid) begin
					state_next = FILL_REQ;
				end
			end
			FILL_REQ: begin
				if (mem_req_ready) begin
					state_next = FILL_WAIT;
				end
			end
			FILL_WAIT: begin
				if (mem_resp_valid) begin
					state_next = LOOKUP; // Retry now hits
				end
			end
			RESPOND: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_write <= cpu_req_write;
			req_addr <= cpu_req_addr;
			req_wdata <= cpu_req_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			missed <= 1'b0;
		end else if (accept) begin
			missed <= 1'b0;
		end else if ((state == LOOKUP) && !tif.hit) begin
			missed <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_hit) begin
			resp_rdata <= dif.word_rdata; // Old word on a write, unused there
		end
	end

	// Both counters move on the edge into RESPOND
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_access <= '0;
			num_hit <= '0;
		end else if (lookup_hit) begin
			num_access <= num_access + 1'b1;
			if (!missed) begin
				num_hit <= num_hit + 1'b1;
			end
		end
	end

	assign cpu_req_ready = (state == IDLE);
	assign cpu_resp_valid = (state == RESPOND);
	assign cpu_resp_rdata = resp_rdata;

	// Request payload comes straight from the stores, stable while waiting
	assign mem_req_valid = (state == WRITEBACK_REQ) || (state == FILL_REQ);
	assign mem_req_write = (state == WRITEBACK_REQ);
	assign mem_req_addr = mem_req_write ? {tif.victim_tag, req_index} : {req_tag, req_index};
	assign mem_req_wdata = dif.line_rdata;

	assign tif.index = req_index;
	assign tif.tag = req_tag;
	assign tif.fill_en = fill_done;
	assign tif.set_dirty = lookup_hit && req_write;
	assign tif.clear_dirty = wb_done;

	assign dif.index = req_index;
	assign dif.offset = req_offset;
	assign dif.word_wdata = req_wdata;
	assign dif.word_we = lookup_hit && req_write;
	assign dif.line_wdata = mem_resp_rdata;
	assign dif.line_we = fill_done;

endmodule

`default_nettype wire

/* cache_top.sv */
`default_nettype none

module cache_top
	import cache_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset_n,

	// Processor port
	input  logic                       cpu_req_valid,
	output logic                       cpu_req_ready,
	input  logic                       cpu_req_write,
	input  logic [ADDR_WIDTH-1:0]      cpu_req_addr,
	input  logic [WORD_SIZE-1:0]       cpu_req_wdata,
	output logic                       cpu_resp_valid,
	output logic [WORD_SIZE-1:0]       cpu_resp_rdata,

	// Line-wide memory port
	output logic                       mem_req_valid,
	input  logic                       mem_req_ready,
	output logic                       mem_req_write,
	output logic [LINE_ADDR_WIDTH-1:0] mem_req_addr,
	output logic [LINE_WIDTH-1:0]      mem_req_wdata,
	input  logic                       mem_resp_valid,
	input  logic [LINE_WIDTH-1:0]      mem_resp_rdata,

	output logic [WORD_SIZE-1:0]       num_access,
	output logic [WORD_SIZE-1:0]       num_hit
);

	tag_if  tif ();
	data_if dif ();

	tag_store u_tag_store (
		.clk     (clk),
		.reset_n (reset_n),
		.tif     (tif.store)
	);

	data_store u_data_store (
		.clk (clk),
		.dif (dif.store)
	);

	cache_controller u_controller (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_req_valid  (cpu_req_valid),
		.cpu_req_ready  (cpu_req_ready),
		.cpu_req_write  (cpu_req_write),
		.cpu_req_addr   (cpu_req_addr),
		.cpu_req_wdata  (cpu_req_wdata),
		.cpu_resp_valid (cpu_resp_valid),
		.cpu_resp_rdata (cpu_resp_rdata),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_write  (mem_req_write),
		.mem_req_addr   (mem_req_addr),
		.mem_req_wdata  (mem_req_wdata),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_rdata (mem_resp_rdata),
		.num_access     (num_access),
		.num_hit        (num_hit),
		.tif            (tif.ctrl),
		.dif            (dif.ctrl)
	);

endmodule

`default_nettype wire

/* tb_cache.sv */
`default_nettype none

module tb_cache
	import cache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLES_PER_TEST = 200;

	typedef struct packed {
		logic                  write;
		logic [ADDR_WIDTH-1:0] addr;
		logic [WORD_SIZE-1:0]  wdata;
	} access_t;

	logic                       clk;
	logic                       reset_n;
	logic                       cpu_req_valid;
	logic                       cpu_req_ready;
	logic                       cpu_req_write;
	logic [ADDR_WIDTH-1:0]      cpu_req_addr;
	logic [WORD_SIZE-1:0]       cpu_req_wdata;
	logic                       cpu_resp_valid;
	logic [WORD_SIZE-1:0]       cpu_resp_rdata;
	logic                       mem_req_valid;
	logic                       mem_req_ready;
	logic                       mem_req_write;
	logic [LINE_ADDR_WIDTH-1:0] mem_req_addr;
	logic [LINE_WIDTH-1:0]      mem_req_wdata;
	logic                       mem_resp_valid;
	logic [LINE_WIDTH-1:0]      mem_resp_rdata;
	logic [WORD_SIZE-1:0]       num_access;
	logic [WORD_SIZE-1:0]       num_hit;

	string       test_names [$];
	access_t     tests [$];
	string       cur_test = "after reset";
	logic [31:0] lfsr_state = 32'h4de35199;

	logic [WORD_SIZE-1:0] main_mem [logic [ADDR_WIDTH-1:0]]; // Memory model contents
	logic [WORD_SIZE-1:0] ref_mem [logic [ADDR_WIDTH-1:0]];  // Processor view
	logic [TAG_WIDTH-1:0] ref_tag [NUM_LINES];
	logic [NUM_LINES-1:0] ref_valid;
	logic [NUM_LINES-1:0] ref_dirty;
	logic [WORD_SIZE-1:0] exp_access;
	logic [WORD_SIZE-1:0] exp_hit;

	logic                       wb_pending;
	logic [LINE_ADDR_WIDTH-1:0] wb_addr;
	logic [LINE_WIDTH-1:0]      wb_data;
	logic                       fill_pending;
	logic [LINE_ADDR_WIDTH-1:0] fill_addr;

	cache_top u_dut (
		.clk            (clk),
		.reset_n        (reset_n),
		.cpu_req_valid  (cpu_req_valid),
		.cpu_req_ready  (cpu_req_ready),
		.cpu_req_write  (cpu_req_write),
		.cpu_req_addr   (cpu_req_addr),
		.cpu_req_wdata  (cpu_req_wdata),
		.cpu_resp_valid (cpu_resp_valid),
		.cpu_resp_rdata (cpu_resp_rdata),
		.mem_req_valid  (mem_req_valid),
		.mem_req_ready  (mem_req_ready),
		.mem_req_write  (mem_req_write),
		.mem_req_addr   (mem_req_addr),
		.mem_req_wdata  (mem_req_wdata),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_rdata (mem_resp_rdata),
		.num_access     (num_access),
		.num_hit        (num_hit)
	);

	function automatic logic [WORD_SIZE-1:0] init_word(input logic [ADDR_WIDTH-1:0] addr);
		return addr ^ 16'h5a3c; // Contents of a word never written
	endfunction

	function automatic logic [WORD_SIZE-1:0] stored_word(input logic [ADDR_WIDTH-1:0] addr);
		return main_mem.exists(addr) ? main_mem[addr] : init_word(addr);
	endfunction

	function automatic logic [WORD_SIZE-1:0] cpu_view_word(input logic [ADDR_WIDTH-1:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : init_word(addr);
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
	endfunction

	function automatic int random_bits(input int count);
		int value;
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
		return value;
	endfunction

	task automatic compare_values(input string what, input logic [LINE_WIDTH-1:0] expected,
			input logic [LINE_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch in %s, %s expected %0h actual %0h", cur_test, what, expected, actual);
			$display("tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic add_test(input string name, input logic write, input logic [ADDR_WIDTH-1:0] addr,
			input logic [WORD_SIZE-1:0] wdata);
		test_names.push_back(name);
		tests.push_back({write, addr, wdata});
	endtask

	task automatic predict_access(input access_t e, output logic hit,
			output logic [WORD_SIZE-1:0] rdata);
		logic [TAG_WIDTH-1:0]  tag;
		logic [INDEX_BITS-1:0] idx;
		logic [ADDR_WIDTH-1:0] a;
		tag = e.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
		idx = e.addr[OFFSET_BITS +: INDEX_BITS];
		hit = ref_valid[idx] && (ref_tag[idx] == tag);
		if (!hit) begin
			if (ref_valid[idx] && ref_dirty[idx]) begin // Victim goes back before the fill
				wb_addr = {ref_tag[idx], idx};
				for (int w = 0; w < LINE_WORDS; w++) begin
					a = {ref_tag[idx], idx, w[OFFSET_BITS-1:0]};
					wb_data[w*WORD_SIZE +: WORD_SIZE] = cpu_view_word(a);
				end
				wb_pending = 1'b1;
			end
			fill_addr = {tag, idx};
			fill_pending = 1'b1;
			ref_valid[idx] = 1'b1;
			ref_tag[idx] = tag;
			ref_dirty[idx] = 1'b0;
		end
		exp_access = exp_access + 1'b1;
		if (hit) begin
			exp_hit = exp_hit + 1'b1;
		end
		if (e.write) begin
			ref_mem[e.addr] = e.wdata;
			ref_dirty[idx] = 1'b1;
		end
		rdata = cpu_view_word(e.addr);
	endtask

	task automatic run_access(input int i);
		access_t              e;
		logic                 hit;
		logic [WORD_SIZE-1:0] exp_rdata;
		int                   cycles;
		e = tests[i];
		cur_test = test_names[i];
		predict_access(e, hit, exp_rdata);
		cpu_req_valid = 1'b1;
		cpu_req_write = e.write;
		cpu_req_addr = e.addr;
		cpu_req_wdata = e.wdata;
		while (!cpu_req_ready) begin
			next_cycle();
		end
		next_cycle(); // Acceptance edge
		cpu_req_valid = 1'b0;
		cycles = 1;
		while (!cpu_resp_valid) begin
			next_cycle();
			cycles++;
		end
		if (!e.write) begin
			compare_values("read data", LINE_WIDTH'(exp_rdata), LINE_WIDTH'(cpu_resp_rdata));
		end
		if (hit) begin
			compare_values("hit response cycle", LINE_WIDTH'(2), LINE_WIDTH'(cycles));
		end
		compare_values("num_access", LINE_WIDTH'(exp_access), LINE_WIDTH'(num_access));
		compare_values("num_hit", LINE_WIDTH'(exp_hit), LINE_WIDTH'(num_hit));
		compare_values("write-back issued", '0, LINE_WIDTH'(wb_pending));
		compare_values("fill issued", '0, LINE_WIDTH'(fill_pending));
		next_cycle();
		compare_values("single response cycle", '0, LINE_WIDTH'(cpu_resp_valid));
	endtask

	task automatic serve_request();
		logic                       write;
		logic [LINE_ADDR_WIDTH-1:0] laddr;
		logic [LINE_WIDTH-1:0]      wdata;
		logic [LINE_WIDTH-1:0]      rdata;
		int                         latency;
		write = mem_req_write;
		laddr = mem_req_addr;
		wdata = mem_req_wdata;
		rdata = '0;
		repeat (random_bits(2)) begin // Stall before taking the request
			next_cycle();
			compare_values("memory request held", LINE_WIDTH'(1), LINE_WIDTH'(mem_req_valid));
			compare_values("memory address held", LINE_WIDTH'(laddr), LINE_WIDTH'(mem_req_addr));
			compare_values("memory data held", wdata, mem_req_wdata);
		end
		mem_req_ready = 1'b1;
		next_cycle();
		mem_req_ready = 1'b0;
		if (write) begin
			compare_values("memory write expected", LINE_WIDTH'(1), LINE_WIDTH'(wb_pending));
			compare_values("write-back address", LINE_WIDTH'(wb_addr), LINE_WIDTH'(laddr));
			compare_values("write-back data", wb_data, wdata);
			wb_pending = 1'b0;
			for (int w = 0; w < LINE_WORDS; w++) begin
				main_mem[{laddr, w[OFFSET_BITS-1:0]}] = wdata[w*WORD_SIZE +: WORD_SIZE];
			end
		end else begin
			compare_values("memory read expected", LINE_WIDTH'(1), LINE_WIDTH'(fill_pending));
			compare_values("fill address", LINE_WIDTH'(fill_addr), LINE_WIDTH'(laddr));
			fill_pending = 1'b0;
			for (int w = 0; w < LINE_WORDS; w++) begin
				rdata[w*WORD_SIZE +: WORD_SIZE] = stored_word({laddr, w[OFFSET_BITS-1:0]});
			end
		end
		latency = 1 + random_bits(2);
		repeat (latency - 1) begin
			next_cycle();
		end
		mem_resp_valid = 1'b1;
		mem_resp_rdata = rdata;
		next_cycle();
		mem_resp_valid = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : memory_model
		forever begin
			next_cycle();
			if (mem_req_valid) begin
				serve_request();
			end
		end
	end

	initial begin
		repeat (RESET_CYCLES + 10) @(posedge clk);
		repeat (tests.size() * CYCLES_PER_TEST) @(posedge clk);
		$display("timeout waiting for response");
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		reset_n = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_write = 1'b0;
		cpu_req_addr = '0;
		cpu_req_wdata = '0;
		mem_req_ready = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp_rdata = '0;
		ref_valid = '0;
		ref_dirty = '0;
		exp_access = '0;
		exp_hit = '0;
		wb_pending = 1'b0;
		fill_pending = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		fill_addr = '0;

		//       name                    write  addr      wdata
		add_test("read miss clean",      1'b0, 16'h0124, 16'h0000);
		add_test("read hit same line",   1'b0, 16'h0125, 16'h0000);
		add_test("write hit",            1'b1, 16'h0126, 16'hbeef);
		add_test("read after write",     1'b0, 16'h0126, 16'h0000);
		add_test("conflict dirty evict", 1'b0, 16'h0524, 16'h0000);
		add_test("read evicted word",    1'b0, 16'h0126, 16'h0000);
		add_test("write miss allocate",  1'b1, 16'h0a3b, 16'h1234);
		add_test("read merged neighbor", 1'b0, 16'h0a38, 16'h0000);
		add_test("read merged word",     1'b0, 16'h0a3b, 16'h0000);
		add_test("write miss index 0",   1'b1, 16'h3300, 16'h5555);
		add_test("write hit index 0",    1'b1, 16'h3303, 16'h6666);
		add_test("evict index 2",        1'b0, 16'h7738, 16'h0000);
		add_test("write evict index 0",  1'b1, 16'h4401, 16'h7777);
		add_test("read back index 0",    1'b0, 16'h3300, 16'h0000);
		add_test("read back index 2",    1'b0, 16'h0a3b, 16'h0000);
		add_test("read hit index 2",     1'b0, 16'h0a39, 16'h0000);

		repeat (RESET_CYCLES) next_cycle();
		reset_n = 1'b1;
		compare_values("ready after reset", LINE_WIDTH'(1), LINE_WIDTH'(cpu_req_ready));
		repeat (4) begin // Nothing moves before the first request
			compare_values("idle cpu_resp_valid", '0, LINE_WIDTH'(cpu_resp_valid));
			compare_values("idle mem_req_valid", '0, LINE_WIDTH'(mem_req_valid));
			compare_values("reset num_access", '0, LINE_WIDTH'(num_access));
			compare_values("reset num_hit", '0, LINE_WIDTH'(num_hit));
			next_cycle();
		end

		for (int i = 0; i < tests.size(); i++) begin
			run_access(i);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
cache_pkg.sv
cache_ifs.sv
tag_store.sv
data_store.sv
cache_controller.sv
cache_top.sv
tb_cache.sv

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_cache \
	-f verilog.f -o sim_cache; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/sim_cache; then
	echo "simulation returned a failing status"
	exit 1
fi

exit 0
